/* Makefile */
# Verilator build and run of the DMA engine testbench
# any variable below can be set on the command line, e.g. make test LOG=run.log

TOP       ?= tb_dma_engine
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: TOP FILELIST BUILD_DIR LOG VERILATOR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/dma_data_fifo.sv */
// ==============================
// pushes while full and pops while empty are dropped
// ==============================
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_data_fifo import dma_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      push,
   input  t_dma_beat push_beat,
   input  logic      pop,
   output t_dma_beat head_beat,
   output logic      not_empty,
   output logic      not_full,
   output logic      almost_full
);

   localparam int DEPTH    = `DMA_DATA_FIFO_DEPTH;
   localparam int PTR_W    = $clog2(DEPTH);
   localparam int CNT_W    = $clog2(DEPTH + 1);
   localparam int AF_LEVEL = DEPTH - `DMA_MAX_OUTSTANDING;

   t_dma_beat        mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign do_push = push && not_full;
   assign do_pop  = pop && not_empty;

   assign head_beat = mem[rd_ptr];
   assign not_empty = (count != '0);
   assign not_full  = (count != CNT_W'(DEPTH));

   // room is kept for every read the engine may still have outstanding
   assign almost_full = (count >= CNT_W'(AF_LEVEL));

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_beat;
      end
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      end
   end

endmodule

/* hdl/dma_descriptor_buffer.sv */
// ==============================
// push only while not_full, pop only while not_empty
// ==============================
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_descriptor_buffer import dma_pkg::*; (
   input  logic            clk,
   input  logic            rst,
   input  logic            push,
   input  t_dma_descriptor push_desc,
   input  logic            pop,
   output t_dma_descriptor head_desc,
   output logic            not_empty,
   output logic            not_full
);

   localparam int DEPTH = `DMA_DESC_BUF_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   t_dma_descriptor  mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   assign head_desc = mem[rd_ptr];
   assign not_empty = (count != '0);
   assign not_full  = (count != CNT_W'(DEPTH));

   always_ff @(posedge clk) begin
      if (push && not_full) begin
         mem[wr_ptr] <= push_desc;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push && not_full) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop && not_empty) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(push && not_full) - CNT_W'(pop && not_empty);
      end
   end

endmodule

/* hdl/dma_engine.sv */
// ==============================
// single channel, simple strobe memory ports
// ==============================
`timescale 1ns/1ps

module dma_engine import dma_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   input  logic             descriptor_fifo_not_empty,
   input  t_dma_descriptor  descriptor,
   input  t_dma_csr_control csr_control,
   input  logic             src_rd_valid,
   input  dma_data_t        src_rd_data,
   input  logic             dest_wr_busy,
   output logic             descriptor_fifo_rdack,
   output logic             src_rd_req,
   output dma_addr_t        src_rd_addr,
   output logic             dest_wr_en,
   output dma_addr_t        dest_wr_addr,
   output dma_data_t        dest_wr_data,
   output logic             desc_done,
   output t_dma_csr_status  wr_dest_status,
   output t_dma_csr_status  rd_src_status,
   output t_dma_fifo_status dma_engine_status
);

   logic            data_fifo_push;
   t_dma_beat       data_fifo_beat;
   logic            data_fifo_almost_full;
   logic            data_fifo_not_full;
   logic            data_fifo_not_empty;
   t_dma_beat       data_fifo_head;
   logic            data_fifo_pop;
   logic            desc_buf_push;
   t_dma_descriptor desc_buf_data;
   logic            desc_buf_not_full;
   logic            desc_buf_not_empty;
   t_dma_descriptor desc_buf_head;
   logic            desc_buf_pop;
   logic            wr_fsm_done;

   assign desc_done = wr_fsm_done;

   always_comb begin
      dma_engine_status.data_fifo_full  = !data_fifo_not_full;
      dma_engine_status.data_fifo_empty = !data_fifo_not_empty;
   end

   dma_read_engine dma_read_engine_inst (
      .clk,
      .rst,
      .csr_control,
      .descriptor_fifo_not_empty,
      .descriptor,
      .desc_buf_not_full,
      .src_rd_valid,
      .src_rd_data,
      .data_fifo_almost_full,
      .descriptor_fifo_rdack,
      .desc_buf_push,
      .desc_buf_data,
      .src_rd_req,
      .src_rd_addr,
      .data_fifo_push,
      .data_fifo_beat,
      .rd_src_status
   );

   dma_data_fifo dma_data_fifo_inst (
      .clk,
      .rst,
      .push        (data_fifo_push),
      .push_beat   (data_fifo_beat),
      .pop         (data_fifo_pop),
      .head_beat   (data_fifo_head),
      .not_empty   (data_fifo_not_empty),
      .not_full    (data_fifo_not_full),
      .almost_full (data_fifo_almost_full)
   );

   // lets the read side run ahead by up to the buffer depth in descriptors
   dma_descriptor_buffer dma_descriptor_buffer_inst (
      .clk,
      .rst,
      .push      (desc_buf_push),
      .push_desc (desc_buf_data),
      .pop       (desc_buf_pop),
      .head_desc (desc_buf_head),
      .not_empty (desc_buf_not_empty),
      .not_full  (desc_buf_not_full)
   );

   dma_write_engine dma_write_engine_inst (
      .clk,
      .rst,
      .csr_control,
      .desc_not_empty (desc_buf_not_empty),
      .desc_head      (desc_buf_head),
      .data_not_empty (data_fifo_not_empty),
      .data_head      (data_fifo_head),
      .dest_wr_busy,
      .desc_pop       (desc_buf_pop),
      .data_pop       (data_fifo_pop),
      .dest_wr_en,
      .dest_wr_addr,
      .dest_wr_data,
      .wr_fsm_done,
      .wr_dest_status
   );

endmodule

/* hdl/dma_pkg.sv */
// ==============================
// shared types of the DMA engine
// ==============================
`include "dma_cfg.svh"

package dma_pkg;

   typedef logic [`DMA_ADDR_W-1:0] dma_addr_t;
   typedef logic [`DMA_DATA_W-1:0] dma_data_t;
   typedef logic [`DMA_LEN_W-1:0]  dma_len_t;
   typedef logic [15:0]            dma_count_t;

   // one transfer, length is in beats and must be nonzero
   typedef struct packed {
      dma_addr_t src_addr;
      dma_addr_t dest_addr;
      dma_len_t  length;
   } t_dma_descriptor;

   // data FIFO payload, the beat followed by its two flags
   typedef struct packed {
      dma_data_t data;
      logic      sop;
      logic      eop;
   } t_dma_beat;

   typedef struct packed {
      logic halt;
   } t_dma_csr_control;

   typedef struct packed {
      logic       busy;
      dma_count_t beat_count;
      dma_count_t desc_count;
   } t_dma_csr_status;

   typedef struct packed {
      logic data_fifo_full;
      logic data_fifo_empty;
   } t_dma_fifo_status;

   typedef enum logic [1:0] {RD_IDLE, RD_ISSUE, RD_DRAIN} rd_state_t;

   typedef enum logic {WR_IDLE, WR_MOVE} wr_state_t;

endpackage

/* hdl/dma_read_engine.sv */
// ==============================
// one descriptor in flight, length must be nonzero
// source memory answers in order and takes every request
// ==============================
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_read_engine import dma_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   input  t_dma_csr_control csr_control,
   input  logic             descriptor_fifo_not_empty,
   input  t_dma_descriptor  descriptor,
   input  logic             desc_buf_not_full,
   input  logic             src_rd_valid,
   input  dma_data_t        src_rd_data,
   input  logic             data_fifo_almost_full,
   output logic             descriptor_fifo_rdack,
   output logic             desc_buf_push,
   output t_dma_descriptor  desc_buf_data,
   output logic             src_rd_req,
   output dma_addr_t        src_rd_addr,
   output logic             data_fifo_push,
   output t_dma_beat        data_fifo_beat,
   output t_dma_csr_status  rd_src_status
);

   localparam int CREDIT_W = $clog2(`DMA_MAX_OUTSTANDING + 1);

   rd_state_t           state;
   t_dma_descriptor     cur_desc;
   dma_addr_t           next_addr;
   dma_len_t            req_left;
   dma_len_t            resp_idx;
   dma_len_t            last_idx;
   logic [CREDIT_W-1:0] outstanding;
   dma_count_t          beat_cnt;
   dma_count_t          desc_cnt;
   logic                accept;
   logic                issue;
   logic                last_resp;

   // a descriptor is taken only when the write side has room to queue it
   assign accept = (state == RD_IDLE) && descriptor_fifo_not_empty &&
                   desc_buf_not_full && !csr_control.halt;

   // the credit check keeps every answer of an issued read room in the data FIFO
   assign issue = (state == RD_ISSUE) && !csr_control.halt &&
                  (outstanding < CREDIT_W'(`DMA_MAX_OUTSTANDING)) &&
                  !data_fifo_almost_full;

   assign last_idx  = cur_desc.length - 1'b1;
   assign last_resp = src_rd_valid && (resp_idx == last_idx);

   // responses go straight into the data FIFO on the edge they arrive
   assign data_fifo_push = src_rd_valid;

   always_comb begin
      data_fifo_beat.data = src_rd_data;
      data_fifo_beat.sop  = (resp_idx == '0);
      data_fifo_beat.eop  = (resp_idx == last_idx);
   end

   assign desc_buf_data = cur_desc;

   always_comb begin
      rd_src_status.busy       = (state != RD_IDLE);
      rd_src_status.beat_count = beat_cnt;
      rd_src_status.desc_count = desc_cnt;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state                 <= RD_IDLE;
         descriptor_fifo_rdack <= 1'b0;
         desc_buf_push         <= 1'b0;
         src_rd_req            <= 1'b0;
         req_left              <= '0;
         resp_idx              <= '0;
         outstanding           <= '0;
         beat_cnt              <= '0;
         desc_cnt              <= '0;
      end else begin
         descriptor_fifo_rdack <= accept;
         desc_buf_push         <= accept;
         src_rd_req            <= issue;
         outstanding <= outstanding + CREDIT_W'(issue) - CREDIT_W'(src_rd_valid);

         case (state)
            RD_IDLE: begin
               if (accept) begin
                  state    <= RD_ISSUE;
                  req_left <= descriptor.length;
                  resp_idx <= '0;
                  desc_cnt <= desc_cnt + 1'b1;
               end
            end
            RD_ISSUE: begin
               if (issue) begin
                  req_left <= req_left - 1'b1;
                  // last request goes out, wait for the remaining answers
                  if (req_left == dma_len_t'(1)) begin
                     state <= RD_DRAIN;
                  end
               end
            end
            RD_DRAIN: begin
               if (last_resp) begin
                  state <= RD_IDLE;
               end
            end
            default: state <= RD_IDLE;
         endcase

         if (src_rd_valid) begin
            resp_idx <= resp_idx + 1'b1;
            beat_cnt <= beat_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_desc  <= descriptor;
         next_addr <= descriptor.src_addr;
      end else if (issue) begin
         next_addr <= next_addr + 1'b1;
      end
      if (issue) begin
         src_rd_addr <= next_addr;
      end
   end

endmodule

/* hdl/dma_write_engine.sv */
// ==============================
// a descriptor ends on the beat flagged eop
// writes are held while dest_wr_busy is high
// ==============================
`timescale 1ns/1ps

module dma_write_engine import dma_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   input  t_dma_csr_control csr_control,
   input  logic             desc_not_empty,
   input  t_dma_descriptor  desc_head,
   input  logic             data_not_empty,
   input  t_dma_beat        data_head,
   input  logic             dest_wr_busy,
   output logic             desc_pop,
   output logic             data_pop,
   output logic             dest_wr_en,
   output dma_addr_t        dest_wr_addr,
   output dma_data_t        dest_wr_data,
   output logic             wr_fsm_done,
   output t_dma_csr_status  wr_dest_status
);

   wr_state_t  state;
   logic       wr_eop;
   logic       wr_done;
   logic       load;
   dma_count_t beat_cnt;
   dma_count_t desc_cnt;

   // the write held on the bus completes on this edge
   assign wr_done = dest_wr_en && !dest_wr_busy;

   // take the next beat when the bus is free or frees up now,
   // but never past the eop of the current descriptor
   assign load = (state == WR_MOVE) && !csr_control.halt && data_not_empty &&
                 (!dest_wr_en || (wr_done && !wr_eop));

   assign desc_pop = (state == WR_IDLE) && desc_not_empty && !csr_control.halt;
   assign data_pop = load;

   always_comb begin
      wr_dest_status.busy       = (state != WR_IDLE);
      wr_dest_status.beat_count = beat_cnt;
      wr_dest_status.desc_count = desc_cnt;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= WR_IDLE;
         dest_wr_en  <= 1'b0;
         wr_fsm_done <= 1'b0;
         beat_cnt    <= '0;
         desc_cnt    <= '0;
      end else begin
         wr_fsm_done <= wr_done && wr_eop;

         case (state)
            WR_IDLE: begin
               if (desc_pop) begin
                  state <= WR_MOVE;
               end
            end
            WR_MOVE: begin
               if (wr_done && wr_eop) begin
                  state <= WR_IDLE;
               end
            end
            default: state <= WR_IDLE;
         endcase

         if (load) begin
            dest_wr_en <= 1'b1;
         end else if (wr_done) begin
            dest_wr_en <= 1'b0;
         end

         if (wr_done) begin
            beat_cnt <= beat_cnt + 1'b1;
         end
         if (wr_done && wr_eop) begin
            desc_cnt <= desc_cnt + 1'b1;
         end
      end
   end

   // the address steps once per completed write
   always_ff @(posedge clk) begin
      if (desc_pop) begin
         dest_wr_addr <= desc_head.dest_addr;
      end else if (wr_done) begin
         dest_wr_addr <= dest_wr_addr + 1'b1;
      end
      if (load) begin
         dest_wr_data <= data_head.data;
         wr_eop       <= data_head.eop;
      end
   end

endmodule

/* include/dma_cfg.svh */
// ==============================
// widths and depths of the DMA engine
// FIFO depths must be powers of two
// ==============================
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// address and beat widths, in bits
`define DMA_ADDR_W 16
`define DMA_DATA_W 32

// descriptor length field, counted in beats
`define DMA_LEN_W 8

// entries in the data FIFO between the two engines
`define DMA_DATA_FIFO_DEPTH 16

// entries in the descriptor buffer
`define DMA_DESC_BUF_DEPTH 4

// read requests that may be unanswered at one time
// the data FIFO keeps this many entries in reserve
`define DMA_MAX_OUTSTANDING 4

`endif

/* sim.f */
+incdir+include
hdl/dma_pkg.sv
hdl/dma_data_fifo.sv
hdl/dma_descriptor_buffer.sv
hdl/dma_read_engine.sv
hdl/dma_write_engine.sv
hdl/dma_engine.sv
verif/tb_dma_engine.sv

/* verif/tb_dma_engine.sv */
// ==============================
// the descriptor FIFO model pops on the edge where rdack is high
// source words are a fixed function of the address
// ==============================
`timescale 1ns/1ps

module tb_dma_engine import dma_pkg::*; ();

   localparam int NUM_DESC   = 8;
   localparam int CLK_PERIOD = 100;
   localparam int HALT_LEN   = 30;

   logic             clk;
   logic             rst;
   logic             descriptor_fifo_not_empty;
   t_dma_descriptor  descriptor;
   t_dma_csr_control csr_control;
   logic             src_rd_valid;
   dma_data_t        src_rd_data;
   logic             dest_wr_busy;
   logic             descriptor_fifo_rdack;
   logic             src_rd_req;
   dma_addr_t        src_rd_addr;
   logic             dest_wr_en;
   dma_addr_t        dest_wr_addr;
   dma_data_t        dest_wr_data;
   logic             desc_done;
   t_dma_csr_status  wr_dest_status;
   t_dma_csr_status  rd_src_status;
   t_dma_fifo_status dma_engine_status;

   integer          seed = 42509;
   t_dma_descriptor desc_q [$];
   dma_addr_t       pend_addr [$];
   int              pend_due [$];
   dma_data_t       dest_mem [0:65535];
   int              desc_rd_ptr = 0;
   int              cycle = 0;
   int              rd_delay;
   int              total_beats = 0;
   int              rdack_count = 0;
   int              write_count = 0;
   int              done_count = 0;
   int              halt_cycles = 0;
   int              errors = 0;
   int              checks = 0;
   logic            rst_q = 1'b0;
   logic            hold_q = 1'b0;
   dma_addr_t       hold_addr;
   dma_data_t       hold_data;

   dma_engine i_dma_engine (
      .clk,
      .rst,
      .descriptor_fifo_not_empty,
      .descriptor,
      .csr_control,
      .src_rd_valid,
      .src_rd_data,
      .dest_wr_busy,
      .descriptor_fifo_rdack,
      .src_rd_req,
      .src_rd_addr,
      .dest_wr_en,
      .dest_wr_addr,
      .dest_wr_data,
      .desc_done,
      .wr_dest_status,
      .rd_src_status,
      .dma_engine_status
   );

   // every bit of the address changes the word
   function automatic dma_data_t src_word(input dma_addr_t addr);
      return {~addr, addr} ^ 32'h5A3C_96E1;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (actual === expected) else begin
         errors++;
         $display("** Error %s: expected %h actual %h", name, expected, actual);
      end
   endtask

   // destinations are packed upward from 0x8000 with a small gap so none overlap
   task automatic build_descriptors();
      t_dma_descriptor d;
      dma_addr_t       dest_next;
      int              i;
      dest_next = 16'h8000;
      for (i = 0; i < NUM_DESC; i++) begin
         d.src_addr  = dma_addr_t'($unsigned($random(seed)) % 32'h7000);
         d.length    = dma_len_t'(1 + $unsigned($random(seed)) % 12);
         d.dest_addr = dest_next;
         dest_next   = dest_next + dma_addr_t'(d.length) + 16'd3;
         desc_q.push_back(d);
         total_beats += int'(d.length);
      end
   endtask

   task automatic check_copy();
      t_dma_descriptor d;
      dma_addr_t       dst;
      int              i;
      int              j;
      for (i = 0; i < NUM_DESC; i++) begin
         d = desc_q[i];
         for (j = 0; j < int'(d.length); j++) begin
            dst = d.dest_addr + dma_addr_t'(j);
            check_value($sformatf("dest_wr_data[%h]", dst),
                        src_word(d.src_addr + dma_addr_t'(j)), dest_mem[dst]);
         end
      end
   endtask

   task automatic check_status();
      check_value("rd_src_status.desc_count", NUM_DESC, rd_src_status.desc_count);
      check_value("wr_dest_status.desc_count", NUM_DESC, wr_dest_status.desc_count);
      check_value("rd_src_status.beat_count", total_beats, rd_src_status.beat_count);
      check_value("wr_dest_status.beat_count", total_beats, wr_dest_status.beat_count);
      check_value("rd_src_status.busy", 0, rd_src_status.busy);
      check_value("wr_dest_status.busy", 0, wr_dest_status.busy);
      check_value("desc_done pulses", NUM_DESC, done_count);
      check_value("descriptor_fifo_rdack pulses", NUM_DESC, rdack_count);
      check_value("completed writes", total_beats, write_count);
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // descriptor FIFO level, source responses and destination busy
   always @(negedge clk) begin
      descriptor_fifo_not_empty = (desc_rd_ptr < desc_q.size());
      descriptor = (desc_rd_ptr < desc_q.size()) ? desc_q[desc_rd_ptr] : '0;
      src_rd_valid = 1'b0;
      src_rd_data  = '0;
      if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
         src_rd_valid = 1'b1;
         src_rd_data  = src_word(pend_addr.pop_front());
         void'(pend_due.pop_front());
      end
      dest_wr_busy = ($unsigned($random(seed)) % 5) < 3;
   end

   always @(posedge clk) begin
      cycle = cycle + 1;
      if (csr_control.halt) begin
         halt_cycles = halt_cycles + 1;
      end else begin
         halt_cycles = 0;
      end

      // covers the late reset cycles and the first cycle after reset
      if (rst_q) begin
         check_value("descriptor_fifo_rdack", 0, descriptor_fifo_rdack);
         check_value("src_rd_req", 0, src_rd_req);
         check_value("dest_wr_en", 0, dest_wr_en);
         check_value("desc_done", 0, desc_done);
         check_value("data_fifo_empty", 1, dma_engine_status.data_fifo_empty);
         check_value("data_fifo_full", 0, dma_engine_status.data_fifo_full);
      end
      rst_q = rst;

      if (hold_q) begin
         check_value("dest_wr_en", 1, dest_wr_en);
         check_value("dest_wr_addr", hold_addr, dest_wr_addr);
         check_value("dest_wr_data", hold_data, dest_wr_data);
      end
      hold_q    = !rst && dest_wr_en && dest_wr_busy;
      hold_addr = dest_wr_addr;
      hold_data = dest_wr_data;

      if (!rst) begin
         // an engine moving data is working on a descriptor
         if (src_rd_req) begin
            check_value("rd_src_status.busy", 1, rd_src_status.busy);
         end
         if (dest_wr_en) begin
            check_value("wr_dest_status.busy", 1, wr_dest_status.busy);
         end

         // in-order source memory with 1 to 4 cycles of latency
         if (src_rd_req) begin
            rd_delay = 1 + int'($unsigned($random(seed)) % 4);
            pend_addr.push_back(src_rd_addr);
            pend_due.push_back(cycle + rd_delay - 1);
         end
         if (dest_wr_en && !dest_wr_busy) begin
            dest_mem[dest_wr_addr] = dest_wr_data;
            write_count++;
         end
         if (descriptor_fifo_rdack) begin
            desc_rd_ptr++;
            rdack_count++;
         end
         if (desc_done) begin
            done_count++;
         end
      end
   end

   assert property (@(posedge clk) disable iff (rst)
                    descriptor_fifo_rdack |-> descriptor_fifo_not_empty)
   else begin
      errors++;
      $display("descriptor_fifo_rdack pulsed while no descriptor was offered");
   end

   assert property (@(posedge clk) disable iff (rst)
                    descriptor_fifo_rdack |-> !$past(descriptor_fifo_rdack))
   else begin
      errors++;
      $display("descriptor_fifo_rdack stayed high for more than one cycle");
   end

   assert property (@(posedge clk) disable iff (rst)
                    (halt_cycles >= 2) |-> !descriptor_fifo_rdack)
   else begin
      errors++;
      $display("a descriptor was popped while halt was high");
   end

   assert property (@(posedge clk) disable iff (rst)
                    (halt_cycles >= 2) |-> !$rose(dest_wr_en))
   else begin
      errors++;
      $display("a new destination write started while halt was high");
   end

   initial begin
      rst          = 1'b1;
      csr_control  = '0;
      descriptor_fifo_not_empty = 1'b0;
      descriptor   = '0;
      src_rd_valid = 1'b0;
      src_rd_data  = '0;
      dest_wr_busy = 1'b0;
      build_descriptors();
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // halt in the middle of the run, then let it finish
      while (rdack_count < 3) @(negedge clk);
      csr_control.halt = 1'b1;
      repeat (HALT_LEN) @(negedge clk);
      csr_control.halt = 1'b0;

      while (done_count < NUM_DESC) @(negedge clk);
      repeat (5) @(negedge clk);
      check_copy();
      check_status();

      $display("closing: %0d checks, %0d errors, %0d descriptors, %0d writes",
               checks, errors, done_count, write_count);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // 20 cycles per beat plus a fixed allowance for reset and the halt window
   initial begin
      wait (total_beats > 0);
      repeat (20 * total_beats + 200) @(posedge clk);
      $display("watchdog: transfers did not complete within %0d cycles",
               20 * total_beats + 200);
      $display("test failed");
      $finish;
   end

endmodule
